//--- lsu_types_pkg.sv
// Load/store pipe widths, size codes, request, packet, region and exception types
`default_nettype none

package lsu_types_pkg;

   // ******************************
   // Widths
   // ******************************
   localparam int XLEN           = 64;
   localparam int DATA_WIDTH     = 64;
   localparam int DMA_DATA_WIDTH = 128;
   localparam int OFFSET_WIDTH   = 12;
   localparam int ADDR_WIDTH     = 32;

   typedef logic [DATA_WIDTH-1:0]   lsu_data_t;
   typedef logic [ADDR_WIDTH-1:0]   lsu_addr_t;
   typedef logic [OFFSET_WIDTH-1:0] lsu_offset_t;

   // Access size, shared by core and DMA
   typedef logic [1:0] lsu_size_t;

   localparam lsu_size_t SIZE_BYTE  = 2'b00;
   localparam lsu_size_t SIZE_HALF  = 2'b01;
   localparam lsu_size_t SIZE_WORD  = 2'b10;
   localparam lsu_size_t SIZE_DWORD = 2'b11;

   // ******************************
   // Pipe packets
   // ******************************
   typedef struct packed {
      logic      valid;
      logic      dma;
      logic      load;
      logic      store;
      logic      unsign;
      lsu_size_t size;
   } lsu_pkt_t;

   typedef struct packed {
      lsu_pkt_t    pkt;
      lsu_data_t   rs1;
      lsu_data_t   rs2;        // store data
      lsu_offset_t offset;
   } lsu_core_req_t;

   typedef struct packed {
      logic                      req;
      lsu_addr_t                 addr;
      lsu_size_t                 sz;
      logic                      write;
      logic [DMA_DATA_WIDTH-1:0] wdata;
   } lsu_dma_req_t;

   // Exactly one flag set for a decoded address
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   typedef struct packed {
      logic      exc_valid;
      logic      exc_type;   // 1 access fault, 0 misaligned
      logic      inst_type;  // 1 store, 0 load
      logic      dma_valid;
      lsu_addr_t addr;
   } lsu_error_pkt_t;

endpackage

`default_nettype wire

//--- lsu_memmap_pkg.sv
// Memory map constants for the data memory and interrupt-controller regions
`default_nettype none

package lsu_memmap_pkg;

   // ******************************
   // Closely coupled data memory
   // ******************************
   localparam lsu_types_pkg::lsu_addr_t DCCM_BASE = 32'hF004_0000;
   localparam lsu_types_pkg::lsu_addr_t DCCM_SIZE = 32'h0001_0000;  // 64 KB

   // ******************************
   // Interrupt-controller registers
   // ******************************
   localparam lsu_types_pkg::lsu_addr_t PIC_BASE = 32'hF00C_0000;
   localparam lsu_types_pkg::lsu_addr_t PIC_SIZE = 32'h0000_8000;   // 32 KB

   // Both sizes are powers of two and each base is aligned to its size,
   // so a region match is a compare of the bits above the size

endpackage

`default_nettype wire

//--- lsu_request_arbiter.sv
// D-stage arbiter: DMA over core, packet build, operand and store data select
`timescale 1ns/100ps
`default_nettype none

module lsu_request_arbiter
   import lsu_types_pkg::*;
(
   input  lsu_core_req_t core,
   input  lsu_dma_req_t  dma,
   input  logic          flush_dc2_up,

   output lsu_pkt_t      pkt_d,
   output lsu_data_t     rs1_d,
   output lsu_offset_t   offset_d,
   output lsu_data_t     store_data_d
);

   logic [DMA_DATA_WIDTH-1:0] dma_wdata_shifted;

   // DMA write data moved down so the addressed byte sits in lane 0
   assign dma_wdata_shifted = dma.wdata >> {dma.addr[3:0], 3'b000};

   always_comb begin
      if (dma.req) begin
         pkt_d.valid  = 1'b1;
         pkt_d.dma    = 1'b1;
         pkt_d.load   = ~dma.write;
         pkt_d.store  = dma.write;
         pkt_d.unsign = 1'b0;
         pkt_d.size   = dma.sz;
         rs1_d        = {{(XLEN-ADDR_WIDTH){1'b0}}, dma.addr};
         offset_d     = '0;
         store_data_d = dma_wdata_shifted[DATA_WIDTH-1:0];
      end else begin
         pkt_d        = core.pkt;
         // Core op dropped at entry when flushed
         pkt_d.valid  = core.pkt.valid & ~flush_dc2_up;
         pkt_d.dma    = 1'b0;
         rs1_d        = core.rs1;
         offset_d     = core.offset;
         store_data_d = core.rs2;
      end
   end

endmodule

`default_nettype wire

//--- lsu_addr_gen.sv
// DC1 operand registers with start and end address generation
`timescale 1ns/100ps
`default_nettype none

module lsu_addr_gen
   import lsu_types_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   input  lsu_pkt_t    pkt_d,
   input  lsu_data_t   rs1_d,
   input  lsu_offset_t offset_d,
   input  lsu_data_t   store_data_d,

   output lsu_pkt_t    pkt_dc1,
   output lsu_data_t   store_data_dc1,
   output lsu_addr_t   addr_dc1,
   output lsu_addr_t   end_addr_dc1
);

   lsu_addr_t   rs1_dc1;
   lsu_offset_t offset_dc1;
   lsu_addr_t   end_offset_dc1;

   // ******************************
   // DC1 registers
   // ******************************
   always_ff @(posedge clk) begin
      pkt_dc1        <= pkt_d;
      rs1_dc1        <= rs1_d[ADDR_WIDTH-1:0];
      offset_dc1     <= offset_d;
      store_data_dc1 <= store_data_d;
      if (reset) begin
         pkt_dc1.valid <= 1'b0;
      end
   end

   // ******************************
   // Address arithmetic
   // ******************************
   assign addr_dc1 = rs1_dc1 +
                     {{(ADDR_WIDTH-OFFSET_WIDTH){offset_dc1[OFFSET_WIDTH-1]}}, offset_dc1};

   // Last byte touched by the access
   always_comb begin
      case (pkt_dc1.size)
         SIZE_BYTE: end_offset_dc1 = lsu_addr_t'(0);
         SIZE_HALF: end_offset_dc1 = lsu_addr_t'(1);
         SIZE_WORD: end_offset_dc1 = lsu_addr_t'(3);
         default:   end_offset_dc1 = lsu_addr_t'(7);
      endcase
   end

   assign end_addr_dc1 = addr_dc1 + end_offset_dc1;

endmodule

`default_nettype wire

//--- lsu_addr_check.sv
// DC1 memory map decode with access and misaligned fault detection
`timescale 1ns/100ps
`default_nettype none

module lsu_addr_check
   import lsu_types_pkg::*;
   import lsu_memmap_pkg::*;
(
   input  lsu_addr_t   addr_dc1,
   input  lsu_addr_t   end_addr_dc1,
   input  lsu_size_t   size,

   output lsu_region_t region_dc1,
   output logic        access_fault,
   output logic        misaligned_fault
);

   lsu_region_t start_region;
   lsu_region_t end_region;
   logic        unaligned;

   function automatic lsu_region_t decode_region(input lsu_addr_t addr);
      lsu_region_t r;
      r.in_dccm  = ((addr ^ DCCM_BASE) & ~(DCCM_SIZE - 1'b1)) == '0;
      r.in_pic   = ((addr ^ PIC_BASE) & ~(PIC_SIZE - 1'b1)) == '0;
      r.external = ~r.in_dccm & ~r.in_pic;
      return r;
   endfunction

   assign start_region = decode_region(addr_dc1);
   assign end_region   = decode_region(end_addr_dc1);
   assign region_dc1   = start_region;

   always_comb begin
      case (size)
         SIZE_BYTE: unaligned = 1'b0;
         SIZE_HALF: unaligned = addr_dc1[0];
         SIZE_WORD: unaligned = |addr_dc1[1:0];
         default:   unaligned = |addr_dc1[2:0];
      endcase
   end

   // ******************************
   // Fault rules
   // ******************************
   // Region crossing, non-word PIC access, or the unmapped hole above DCCM_BASE
   assign access_fault = (start_region != end_region) |
                         (start_region.in_pic & (size != SIZE_WORD)) |
                         (start_region.external & (addr_dc1 >= DCCM_BASE));

   // Memory regions take unaligned accesses, the bus does not
   assign misaligned_fault = start_region.external & unaligned;

endmodule

`default_nettype wire

//--- lsu_pipe_ctl.sv
// DC2 to DC5 stage registers, flush kills, DC3 exception packet and DC5 commit
`timescale 1ns/100ps
`default_nettype none

module lsu_pipe_ctl
   import lsu_types_pkg::*;
(
   input  logic           clk,
   input  logic           reset,

   input  lsu_pkt_t       pkt_dc1,
   input  lsu_addr_t      addr_dc1,
   input  lsu_data_t      store_data_dc1,
   input  lsu_region_t    region_dc1,
   input  logic           access_fault,
   input  logic           misaligned_fault,

   input  logic           flush_dc2_up,
   input  logic           flush_dc3,
   input  logic           flush_dc4,
   input  logic           flush_dc5,
   input  logic           ld_bus_error_dc3,

   output lsu_pkt_t       pkt_dc3,
   output lsu_addr_t      addr_dc3,
   output lsu_region_t    region_dc3,
   output lsu_error_pkt_t error_pkt_dc3,
   output lsu_addr_t      addr_dc5,
   output lsu_data_t      store_data_dc5,
   output logic           commit_dc5
);

   lsu_pkt_t    pkt_dc2, pkt_dc4, pkt_dc5;
   lsu_addr_t   addr_dc2, addr_dc4;
   lsu_region_t region_dc2;
   lsu_data_t   store_data_dc2, store_data_dc3, store_data_dc4;
   logic        access_fault_dc2, access_fault_dc3;
   logic        misaligned_fault_dc2, misaligned_fault_dc3;

   // ******************************
   // Stage registers
   // ******************************
   // Flushes kill core ops only, DMA always drains
   always_ff @(posedge clk) begin
      pkt_dc2              <= pkt_dc1;
      pkt_dc2.valid        <= pkt_dc1.valid & ~(flush_dc2_up & ~pkt_dc1.dma);
      addr_dc2             <= addr_dc1;
      region_dc2           <= region_dc1;
      access_fault_dc2     <= access_fault;
      misaligned_fault_dc2 <= misaligned_fault;
      store_data_dc2       <= store_data_dc1;

      pkt_dc3              <= pkt_dc2;
      pkt_dc3.valid        <= pkt_dc2.valid & ~(flush_dc2_up & ~pkt_dc2.dma);
      addr_dc3             <= addr_dc2;
      region_dc3           <= region_dc2;
      access_fault_dc3     <= access_fault_dc2;
      misaligned_fault_dc3 <= misaligned_fault_dc2;
      store_data_dc3       <= store_data_dc2;

      pkt_dc4              <= pkt_dc3;
      pkt_dc4.valid        <= pkt_dc3.valid & ~(flush_dc3 & ~pkt_dc3.dma);
      addr_dc4             <= addr_dc3;
      store_data_dc4       <= store_data_dc3;

      pkt_dc5              <= pkt_dc4;
      pkt_dc5.valid        <= pkt_dc4.valid & ~(flush_dc4 & ~pkt_dc4.dma);
      addr_dc5             <= addr_dc4;
      store_data_dc5       <= store_data_dc4;

      if (reset) begin
         pkt_dc2.valid <= 1'b0;
         pkt_dc3.valid <= 1'b0;
         pkt_dc4.valid <= 1'b0;
         pkt_dc5.valid <= 1'b0;
      end
   end

   // ******************************
   // DC3 exception packet
   // ******************************
   assign error_pkt_dc3.exc_valid = (access_fault_dc3 | misaligned_fault_dc3 | ld_bus_error_dc3) &
                                    pkt_dc3.valid & ~pkt_dc3.dma & ~flush_dc3;
   assign error_pkt_dc3.exc_type  = ~misaligned_fault_dc3;
   assign error_pkt_dc3.inst_type = pkt_dc3.store;
   assign error_pkt_dc3.dma_valid = pkt_dc3.dma;
   assign error_pkt_dc3.addr      = addr_dc3;

   // DMA completes without retiring an instruction
   assign commit_dc5 = pkt_dc5.valid & (pkt_dc5.load | pkt_dc5.store) &
                       ~pkt_dc5.dma & ~flush_dc5;

endmodule

`default_nettype wire

//--- lsu_load_align.sv
// DC3 load data source select with size and sign extension
`timescale 1ns/100ps
`default_nettype none

module lsu_load_align
   import lsu_types_pkg::*;
(
   input  lsu_pkt_t    pkt_dc3,
   input  lsu_region_t region_dc3,
   input  lsu_data_t   ld_data_dc3,
   input  lsu_data_t   bus_read_data_dc3,

   output lsu_data_t   result_dc3
);

   lsu_data_t ld_src_dc3;

   // External loads come back on the bus
   assign ld_src_dc3 = region_dc3.external ? bus_read_data_dc3 : ld_data_dc3;

   always_comb begin
      case (pkt_dc3.size)
         SIZE_BYTE: begin
            result_dc3 = pkt_dc3.unsign ? {56'b0, ld_src_dc3[7:0]} :
                                          {{56{ld_src_dc3[7]}}, ld_src_dc3[7:0]};
         end
         SIZE_HALF: begin
            result_dc3 = pkt_dc3.unsign ? {48'b0, ld_src_dc3[15:0]} :
                                          {{48{ld_src_dc3[15]}}, ld_src_dc3[15:0]};
         end
         SIZE_WORD: begin
            result_dc3 = pkt_dc3.unsign ? {32'b0, ld_src_dc3[31:0]} :
                                          {{32{ld_src_dc3[31]}}, ld_src_dc3[31:0]};
         end
         default: begin
            result_dc3 = ld_src_dc3;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- lsu_lsc_top.sv
// Load/store control pipe top: arbiter, address path, stage control, load format
`timescale 1ns/100ps
`default_nettype none

module lsu_lsc_top
   import lsu_types_pkg::*;
(
   input  logic           clk,
   input  logic           reset,

   input  lsu_core_req_t  core,
   input  lsu_dma_req_t   dma,

   input  logic           flush_dc2_up,
   input  logic           flush_dc3,
   input  logic           flush_dc4,
   input  logic           flush_dc5,

   input  lsu_data_t      ld_data_dc3,
   input  lsu_data_t      bus_read_data_dc3,
   input  logic           ld_bus_error_dc3,

   output lsu_addr_t      addr_dc3,
   output lsu_region_t    region_dc3,
   output lsu_data_t      result_dc3,
   output lsu_error_pkt_t error_pkt_dc3,
   output lsu_addr_t      addr_dc5,
   output lsu_data_t      store_data_dc5,
   output logic           commit_dc5
);

   lsu_pkt_t    pkt_d, pkt_dc1, pkt_dc3;
   lsu_data_t   rs1_d, store_data_d, store_data_dc1;
   lsu_offset_t offset_d;
   lsu_addr_t   addr_dc1, end_addr_dc1;
   lsu_region_t region_dc1;
   logic        access_fault, misaligned_fault;

   // ******************************
   // D stage and DC1
   // ******************************
   lsu_request_arbiter arb_i (
      .core         (core),
      .dma          (dma),
      .flush_dc2_up (flush_dc2_up),
      .pkt_d        (pkt_d),
      .rs1_d        (rs1_d),
      .offset_d     (offset_d),
      .store_data_d (store_data_d)
   );

   lsu_addr_gen addr_gen_i (
      .clk            (clk),
      .reset          (reset),
      .pkt_d          (pkt_d),
      .rs1_d          (rs1_d),
      .offset_d       (offset_d),
      .store_data_d   (store_data_d),
      .pkt_dc1        (pkt_dc1),
      .store_data_dc1 (store_data_dc1),
      .addr_dc1       (addr_dc1),
      .end_addr_dc1   (end_addr_dc1)
   );

   lsu_addr_check addr_check_i (
      .addr_dc1         (addr_dc1),
      .end_addr_dc1     (end_addr_dc1),
      .size             (pkt_dc1.size),
      .region_dc1       (region_dc1),
      .access_fault     (access_fault),
      .misaligned_fault (misaligned_fault)
   );

   // ******************************
   // DC2 to DC5
   // ******************************
   lsu_pipe_ctl pipe_ctl_i (
      .clk              (clk),
      .reset            (reset),
      .pkt_dc1          (pkt_dc1),
      .addr_dc1         (addr_dc1),
      .store_data_dc1   (store_data_dc1),
      .region_dc1       (region_dc1),
      .access_fault     (access_fault),
      .misaligned_fault (misaligned_fault),
      .flush_dc2_up     (flush_dc2_up),
      .flush_dc3        (flush_dc3),
      .flush_dc4        (flush_dc4),
      .flush_dc5        (flush_dc5),
      .ld_bus_error_dc3 (ld_bus_error_dc3),
      .pkt_dc3          (pkt_dc3),
      .addr_dc3         (addr_dc3),
      .region_dc3       (region_dc3),
      .error_pkt_dc3    (error_pkt_dc3),
      .addr_dc5         (addr_dc5),
      .store_data_dc5   (store_data_dc5),
      .commit_dc5       (commit_dc5)
   );

   lsu_load_align load_align_i (
      .pkt_dc3           (pkt_dc3),
      .region_dc3        (region_dc3),
      .ld_data_dc3       (ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .result_dc3        (result_dc3)
   );

endmodule

`default_nettype wire

//--- tb_lsu_lsc.sv
// Load/store control pipe testbench with stimulus table, reference model, LCG and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_lsc
   import lsu_types_pkg::*;
   import lsu_memmap_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int DRAIN_CYCLES = 6;

   // Flush bits {dc5, dc4, dc3, dc2_up} aimed at the row's own op
   typedef struct packed {
      lsu_core_req_t core;
      lsu_dma_req_t  dma;
      logic [3:0]    flush;
      logic          bus_error;
      lsu_data_t     ld_data;
      lsu_data_t     bus_data;
   } stim_t;

   typedef struct packed {
      lsu_addr_t   addr;
      lsu_region_t region;
      lsu_data_t   result;
      logic        exc_valid;
      logic        exc_type;
      logic        inst_type;
      logic        dma_valid;
      lsu_data_t   store_data;
      logic        commit;
   } expect_t;

   typedef struct packed {
      stim_t   stim;
      expect_t exp;
   } row_t;

   logic           clk;
   logic           reset;
   lsu_core_req_t  core;
   lsu_dma_req_t   dma;
   logic           flush_dc2_up;
   logic           flush_dc3;
   logic           flush_dc4;
   logic           flush_dc5;
   lsu_data_t      ld_data_dc3;
   lsu_data_t      bus_read_data_dc3;
   logic           ld_bus_error_dc3;
   lsu_addr_t      addr_dc3;
   lsu_region_t    region_dc3;
   lsu_data_t      result_dc3;
   lsu_error_pkt_t error_pkt_dc3;
   lsu_addr_t      addr_dc5;
   lsu_data_t      store_data_dc5;
   logic           commit_dc5;

   row_t        table_q[$];
   // Inputs per cycle indexed by the cycle they are driven in
   logic [3:0]  flush_at[$];
   logic        bus_error_at[$];
   lsu_data_t   ld_data_at[$];
   lsu_data_t   bus_data_at[$];
   logic [31:0] lcg_state;
   logic        table_ready;

   lsu_lsc_top dut_i (
      .clk               (clk),
      .reset             (reset),
      .core              (core),
      .dma               (dma),
      .flush_dc2_up      (flush_dc2_up),
      .flush_dc3         (flush_dc3),
      .flush_dc4         (flush_dc4),
      .flush_dc5         (flush_dc5),
      .ld_data_dc3       (ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_bus_error_dc3  (ld_bus_error_dc3),
      .addr_dc3          (addr_dc3),
      .region_dc3        (region_dc3),
      .result_dc3        (result_dc3),
      .error_pkt_dc3     (error_pkt_dc3),
      .addr_dc5          (addr_dc5),
      .store_data_dc5    (store_data_dc5),
      .commit_dc5        (commit_dc5)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ******************************
   // Random values and reference model
   // ******************************
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic lsu_data_t rand64();
      return {next_rand(), next_rand()};
   endfunction

   function automatic lsu_region_t region_of(input lsu_addr_t a);
      lsu_region_t r;
      r.in_dccm  = (a >= DCCM_BASE) && (a < DCCM_BASE + DCCM_SIZE);
      r.in_pic   = (a >= PIC_BASE) && (a < PIC_BASE + PIC_SIZE);
      r.external = !r.in_dccm && !r.in_pic;
      return r;
   endfunction

   function automatic lsu_data_t extend_load(input lsu_data_t d, input lsu_size_t size,
                                             input logic unsign);
      int        bits;
      lsu_data_t mask;
      bits = 8 << size;
      if (bits == 64) begin
         return d;
      end
      mask = (64'd1 << bits) - 64'd1;
      if (!unsign && d[bits-1]) begin
         return d | ~mask;
      end
      return d & mask;
   endfunction

   // ******************************
   // Table construction
   // ******************************
   task automatic add_core(input logic store, input logic unsign, input lsu_size_t size,
                           input lsu_addr_t base, input lsu_offset_t offset,
                           input logic [3:0] flush, input logic bus_error);
      row_t r;
      r = '0;
      r.stim.core.pkt.valid  = 1'b1;
      r.stim.core.pkt.load   = ~store;
      r.stim.core.pkt.store  = store;
      r.stim.core.pkt.unsign = unsign;
      r.stim.core.pkt.size   = size;
      // Upper rs1 bits are not part of the address
      r.stim.core.rs1        = {next_rand(), base};
      r.stim.core.rs2        = rand64();
      r.stim.core.offset     = offset;
      r.stim.flush           = flush;
      r.stim.bus_error       = bus_error;
      r.stim.ld_data         = rand64();
      r.stim.bus_data        = rand64();
      table_q.push_back(r);
   endtask

   task automatic add_idle();
      row_t r;
      r = '0;
      table_q.push_back(r);
   endtask

   // DMA row with a competing core load that must lose
   task automatic add_dma(input logic write, input lsu_size_t size, input lsu_addr_t addr,
                          input logic [3:0] flush);
      row_t r;
      r = '0;
      r.stim.dma.req        = 1'b1;
      r.stim.dma.addr       = addr;
      r.stim.dma.sz         = size;
      r.stim.dma.write      = write;
      r.stim.dma.wdata      = {rand64(), rand64()};
      r.stim.core.pkt.valid = 1'b1;
      r.stim.core.pkt.load  = 1'b1;
      r.stim.core.pkt.size  = SIZE_WORD;
      r.stim.core.rs1       = rand64();
      r.stim.core.rs2       = rand64();
      r.stim.core.offset    = 12'h010;
      r.stim.flush          = flush;
      r.stim.ld_data        = rand64();
      r.stim.bus_data       = rand64();
      table_q.push_back(r);
   endtask

   task automatic build_table();
      lsu_addr_t a;
      int        i;
      // Data memory loads of every size, signed and unsigned, with both offset signs
      for (i = 0; i < 8; i++) begin
         a = DCCM_BASE + 32'h100 + (next_rand() & 32'h0000_7FF8);
         add_core(1'b0, i[0], lsu_size_t'(i >> 1), a, i[0] ? 12'hFE0 : 12'h018, 4'b0, 1'b0);
      end
      for (i = 0; i < 2; i++) begin
         a = PIC_BASE + (next_rand() & 32'h0000_3FF0);
         add_core(1'b0, i[0], SIZE_WORD, a, 12'h004, 4'b0, 1'b0);
      end
      // External loads come from the bus data
      for (i = 0; i < 4; i++) begin
         a = 32'h2000_0000 + (next_rand() & 32'h00FF_FFF0);
         add_core(1'b0, i[0], lsu_size_t'(i), a, 12'hFF8, 4'b0, 1'b0);
      end
      // Faults and then two accesses that must stay clean
      add_core(1'b0, 1'b0, SIZE_DWORD, DCCM_BASE + 32'h0000_FFFC, 12'h000, 4'b0, 1'b0);
      add_core(1'b1, 1'b0, SIZE_HALF, PIC_BASE + 32'h10, 12'h002, 4'b0, 1'b0);
      add_core(1'b0, 1'b1, SIZE_WORD, 32'h2000_1002, 12'h000, 4'b0, 1'b0);
      add_core(1'b0, 1'b0, SIZE_DWORD, 32'h2000_2000, 12'h000, 4'b0, 1'b1);
      add_core(1'b1, 1'b0, SIZE_WORD, 32'hF008_0000, 12'h000, 4'b0, 1'b0);
      add_core(1'b0, 1'b0, SIZE_WORD, DCCM_BASE + 32'h22, 12'h000, 4'b0, 1'b0);
      add_core(1'b1, 1'b0, SIZE_DWORD, DCCM_BASE + 32'h40, 12'h000, 4'b0, 1'b0);
      // DMA wins over core and a faulting DMA sees every flush
      add_dma(1'b1, SIZE_WORD, DCCM_BASE + 32'h35, 4'b0);
      add_dma(1'b0, SIZE_WORD, PIC_BASE + 32'h8, 4'b0);
      add_dma(1'b0, SIZE_BYTE, PIC_BASE + 32'h1, 4'b1111);
      add_idle();
      // One flush per core op
      add_core(1'b0, 1'b0, SIZE_HALF, PIC_BASE + 32'h4, 12'h000, 4'b0010, 1'b0);
      add_core(1'b1, 1'b0, SIZE_DWORD, DCCM_BASE + 32'h200, 12'h000, 4'b0100, 1'b0);
      add_core(1'b0, 1'b1, SIZE_BYTE, DCCM_BASE + 32'h301, 12'h000, 4'b1000, 1'b0);
      // Neighbours of the flush_dc2_up op die in DC2 and in D
      add_core(1'b0, 1'b0, SIZE_WORD, DCCM_BASE + 32'h90, 12'h000, 4'b0, 1'b0);
      add_core(1'b1, 1'b0, SIZE_WORD, DCCM_BASE + 32'h80, 12'h000, 4'b0001, 1'b0);
      add_core(1'b1, 1'b0, SIZE_HALF, DCCM_BASE + 32'hA0, 12'h000, 4'b0, 1'b0);
      add_dma(1'b1, SIZE_DWORD, 32'h3000_0008, 4'b0);
      // Back-to-back stores
      for (i = 0; i < 6; i++) begin
         a = DCCM_BASE + (next_rand() & 32'h0000_FFF8);
         add_core(1'b1, 1'b0, SIZE_DWORD, a, 12'h000, 4'b0, 1'b0);
      end
   endtask

   task automatic schedule_cycles();
      int n;
      int c;
      int q;
      n = table_q.size();
      for (c = 0; c < n + DRAIN_CYCLES; c++) begin
         flush_at.push_back(4'b0000);
         bus_error_at.push_back(1'b0);
         ld_data_at.push_back('0);
         bus_data_at.push_back('0);
      end
      // Each flush is raised while the op sits in the stage it names
      for (q = 0; q < n; q++) begin
         flush_at[q+1]     = flush_at[q+1] | {3'b000, table_q[q].stim.flush[0]};
         flush_at[q+3]     = flush_at[q+3] | {2'b00, table_q[q].stim.flush[1], 1'b0};
         flush_at[q+4]     = flush_at[q+4] | {1'b0, table_q[q].stim.flush[2], 2'b00};
         flush_at[q+5]     = flush_at[q+5] | {table_q[q].stim.flush[3], 3'b000};
         bus_error_at[q+3] = table_q[q].stim.bus_error;
         ld_data_at[q+3]   = table_q[q].stim.ld_data;
         bus_data_at[q+3]  = table_q[q].stim.bus_data;
      end
   endtask

   task automatic compute_expected();
      row_t                      r;
      stim_t                     s;
      expect_t                   e;
      lsu_addr_t                 addr;
      lsu_addr_t                 mask;
      lsu_size_t                 size;
      lsu_region_t               r_end;
      logic [DMA_DATA_WIDTH-1:0] wide;
      logic                      is_dma, valid, load, store, unsign, af, mf, v3, v5;
      int                        q;
      for (q = 0; q < table_q.size(); q++) begin
         r      = table_q[q];
         s      = r.stim;
         e      = '0;
         is_dma = s.dma.req;
         if (is_dma) begin
            addr         = s.dma.addr;
            size         = s.dma.sz;
            valid        = 1'b1;
            load         = ~s.dma.write;
            store        = s.dma.write;
            unsign       = 1'b0;
            wide         = s.dma.wdata >> (8 * s.dma.addr[3:0]);
            e.store_data = wide[63:0];
         end else begin
            addr         = s.core.rs1[31:0] + {{20{s.core.offset[11]}}, s.core.offset};
            size         = s.core.pkt.size;
            valid        = s.core.pkt.valid;
            load         = s.core.pkt.load;
            store        = s.core.pkt.store;
            unsign       = s.core.pkt.unsign;
            e.store_data = s.core.rs2;
         end
         mask     = (32'd1 << size) - 32'd1;
         e.addr   = addr;
         e.region = region_of(addr);
         r_end    = region_of(addr + mask);
         af = (e.region != r_end) || (e.region.in_pic && size != SIZE_WORD) ||
              (e.region.external && addr >= DCCM_BASE);
         mf = e.region.external && ((addr & mask) != 32'd0);
         // Core ops die on flush_dc2_up while in D, DC1 or DC2
         v3 = valid && (is_dma || !(flush_at[q][0] || flush_at[q+1][0] || flush_at[q+2][0]));
         v5 = v3 && (is_dma || !(flush_at[q+3][1] || flush_at[q+4][2]));
         e.result    = extend_load(e.region.external ? bus_data_at[q+3] : ld_data_at[q+3],
                                   size, unsign);
         e.exc_valid = (af || mf || bus_error_at[q+3]) && v3 && !is_dma && !flush_at[q+3][1];
         e.exc_type  = ~mf;
         e.inst_type = store;
         e.dma_valid = is_dma;
         e.commit    = v5 && (load || store) && !is_dma && !flush_at[q+5][3];
         r.exp       = e;
         table_q[q]  = r;
      end
   endtask

   // ******************************
   // Drive and check
   // ******************************
   task automatic compare_value(input string what, input int row,
                                input logic [63:0] actual, input logic [63:0] expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s of row %0d is %h, expected %h",
                  $time, what, row, actual, expected);
         $display("Test failures found");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic drive_cycle(input int c);
      if (c < table_q.size()) begin
         core <= table_q[c].stim.core;
         dma  <= table_q[c].stim.dma;
      end else begin
         core <= '0;
         dma  <= '0;
      end
      flush_dc2_up      <= flush_at[c][0];
      flush_dc3         <= flush_at[c][1];
      flush_dc4         <= flush_at[c][2];
      flush_dc5         <= flush_at[c][3];
      ld_bus_error_dc3  <= bus_error_at[c];
      ld_data_dc3       <= ld_data_at[c];
      bus_read_data_dc3 <= bus_data_at[c];
   endtask

   task automatic check_cycle(input int c);
      expect_t e;
      if (c >= 3 && c - 3 < table_q.size()) begin
         e = table_q[c-3].exp;
         compare_value("addr_dc3", c - 3, addr_dc3, e.addr);
         compare_value("region_dc3", c - 3, region_dc3, e.region);
         compare_value("result_dc3", c - 3, result_dc3, e.result);
         compare_value("exc_valid", c - 3, error_pkt_dc3.exc_valid, e.exc_valid);
         compare_value("dma_valid", c - 3, error_pkt_dc3.dma_valid, e.dma_valid);
         if (e.exc_valid) begin
            compare_value("exc_type", c - 3, error_pkt_dc3.exc_type, e.exc_type);
            compare_value("inst_type", c - 3, error_pkt_dc3.inst_type, e.inst_type);
            compare_value("exc addr", c - 3, error_pkt_dc3.addr, e.addr);
         end
      end
      if (c >= 5 && c - 5 < table_q.size()) begin
         e = table_q[c-5].exp;
         compare_value("addr_dc5", c - 5, addr_dc5, e.addr);
         compare_value("store_data_dc5", c - 5, store_data_dc5, e.store_data);
         compare_value("commit_dc5", c - 5, commit_dc5, e.commit);
      end
   endtask

   initial begin
      int c;
      lcg_state         = 32'hc0b466db;
      table_ready       = 1'b0;
      reset             = 1'b1;
      core              = '0;
      dma               = '0;
      flush_dc2_up      = 1'b0;
      flush_dc3         = 1'b0;
      flush_dc4         = 1'b0;
      flush_dc5         = 1'b0;
      ld_data_dc3       = '0;
      bus_read_data_dc3 = '0;
      ld_bus_error_dc3  = 1'b0;
      build_table();
      schedule_cycles();
      compute_expected();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      // Inputs change on the rising edge and outputs are read on the falling edge
      for (c = 0; c < table_q.size() + DRAIN_CYCLES; c++) begin
         @(posedge clk);
         drive_cycle(c);
         @(negedge clk);
         check_cycle(c);
      end
      $display("All tests passed!");
      $finish;
   end

   // Watchdog
   initial begin
      wait (table_ready);
      #((table_q.size() + 20) * CLK_PERIOD);
      $display("Test failures found");
      $fatal(1, "Timeout: the run did not finish in the expected number of cycles");
   end

endmodule

`default_nettype wire

//--- files.f
lsu_types_pkg.sv
lsu_memmap_pkg.sv
lsu_request_arbiter.sv
lsu_addr_gen.sv
lsu_addr_check.sv
lsu_pipe_ctl.sv
lsu_load_align.sv
lsu_lsc_top.sv
tb_lsu_lsc.sv

//--- Makefile
# Verilator build and run of the load/store control pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_lsc
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
